/* list.f */
+incdir+source
source/flappy_pkg.sv
source/bird_physics.sv
source/pipe_track.sv
source/game_ctrl.sv
source/layer_hit.sv
source/pixel_compose.sv
source/flappy_pic.sv
bench/flappy_props.sv
bench/tb_flappy.sv

/* Makefile */
# Verilator flow for the flappy pixel pipeline
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_flappy
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_flappy.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_flappy;
    import flappy_pkg::*;

    localparam int num_frames  = 400;
    localparam int half_period = 20;
    localparam int frame_max   = 14;    // 12 pixels, a flap cycle and the frame end
    localparam int watchdog_ns = num_frames * frame_max * 2 * half_period * 2;
    localparam int over_limit  = 20;    // dimmed frames before a restart

    logic    vga_clk;
    logic    sys_rst_n;
    coord_t  pix_x;
    coord_t  pix_y;
    logic    bird_ctrl;
    rgb565_t pix_data;
    logic    game_over;
    score_t  score;

    logic [31:0] rng;
    logic        m_started;
    logic        m_over;
    logic        m_flap;
    logic [4:0]  m_phase;
    logic [4:0]  m_speed;
    logic [9:0]  m_bird_y;
    coord_t      m_off [2];
    coord_t      m_gap [2];
    logic        m_launched1;       // second pipe released
    logic [7:0]  m_lfsr;
    score_t      m_score;
    logic [35:0] exp_q [$];         // x, y, expected colour
    int          err_pix;
    int          err_score;
    int          err_over;

    flappy_pic dut_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .bird_ctrl (bird_ctrl),
        .pix_data  (pix_data),
        .game_over (game_over),
        .score     (score)
    );

    bind flappy_pic flappy_props props_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_data  (pix_data),
        .game_over (game_over),
        .score     (score)
    );

    always #(half_period) vga_clk = ~vga_clk;

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic rgb565_t dimmed(input rgb565_t c);
        int b;
        int g;
        int r;
        b = int'(c[4:0]) * 30 / 100;
        g = int'(c[10:5]) * 39 / 100;
        r = int'(c[15:11]) * 11 / 100;
        return {r[4:0], g[5:0], b[4:0]};
    endfunction

    // head and body boxes of pipe p
    function automatic logic pipe_covers(input int x, input int y, input int p);
        int   left;
        int   g;
        logic head;
        logic body;
        left = 464 - int'(m_off[p]);
        g    = int'(m_gap[p]);
        head = (x >= left) && (x <= left + 51) &&
               (((y >= g) && (y < g + 24)) || ((y >= g + 134) && (y < g + 158)));
        body = (x >= left + 2) && (x <= left + 49) &&
               ((y < g) || ((y >= g + 158) && (y < 420)));
        return head || body;
    endfunction

    function automatic logic collision();
        int   top;
        int   bottom;
        int   left;
        int   p;
        logic hit;
        top    = 453 - int'(m_bird_y);
        bottom = 480 - int'(m_bird_y);
        hit    = (m_bird_y <= 10'd60) || (top <= 0);
        for (p = 0; p < 2; p++) begin
            left = 464 - int'(m_off[p]);
            if ((337 >= left + 2) && (337 <= left + 49) &&
                ((top <= int'(m_gap[p]) + 24) || (bottom >= int'(m_gap[p]) + 158))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic rgb565_t pixel_colour(input int x, input int y);
        rgb565_t c;
        int      top;
        top = 453 - int'(m_bird_y);
        if ((x < 176) || (x >= 464)) c = 16'h0000;
        else if (pipe_covers(x, y, 0) || pipe_covers(x, y, 1)) c = 16'h07E0;
        else if ((x >= 303) && (x <= 336) && (y >= top) && (y < top + 27)) c = 16'hFFE0;
        else if (y >= 442) c = 16'hDED2;
        else if (y >= 440) c = 16'hD549;
        else if (y >= 438) c = 16'h5404;
        else if (y >= 424) c = 16'hDED2;   // land body
        else if (y >= 422) c = 16'hE7F1;
        else if (y >= 420) c = 16'h51C8;
        else c = 16'h4E19;
        return m_over ? dimmed(c) : c;
    endfunction

    task automatic model_reset();
        m_started   = 1'b0;
        m_over      = 1'b0;
        m_flap      = 1'b0;
        m_phase     = 5'd0;
        m_speed     = 5'd0;
        m_bird_y    = 10'd226;
        m_off[0]    = 10'd0;
        m_off[1]    = 10'd0;
        m_gap[0]    = 10'd150;
        m_gap[1]    = 10'h0A5;
        m_launched1 = 1'b0;
        m_lfsr      = 8'hA5;
        m_score     = 20'd0;
        exp_q.delete();
    endtask

    // one rising edge of the game state
    task automatic model_step(input coord_t x, input coord_t y, input logic ctrl);
        logic       frame_end;
        logic       run;
        logic       hit;
        logic       launch1;
        logic       flap_old;
        logic [4:0] speed_old;
        coord_t     gap_next;
        int         p;
        frame_end = (x == 10'd639) && (y == 10'd479);
        run       = m_started && !m_over;
        hit       = collision();
        launch1   = (m_off[0] == 10'd170);
        flap_old  = m_flap;
        speed_old = m_speed;
        gap_next  = 10'd40 + {3'b000, m_lfsr[6:0]};
        if (frame_end) begin
            if (!m_over && ((m_off[0] == 10'd170) || (m_off[1] == 10'd170))) begin
                m_score = m_score + 20'd1;
            end
            m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5] ^ m_lfsr[4] ^ m_lfsr[3]};
            if (m_over) begin
                m_speed = 5'd0;
            end else if (run && flap_old) begin
                m_bird_y = m_bird_y + 10'(speed_old);
                m_speed  = (m_phase < 5'd5)  ? 5'd6 :
                           (m_phase < 5'd10) ? 5'd4 :
                           (m_phase < 5'd15) ? 5'd2 :
                           (m_phase < 5'd20) ? 5'd1 : 5'd0;
                m_phase  = (m_phase >= 5'd20) ? 5'd0 : m_phase + 5'd1;
            end else if (run) begin
                m_bird_y = m_bird_y - 10'(speed_old);
                if (m_phase >= 5'd3) begin
                    m_speed = speed_old + 5'd1;
                    m_phase = 5'd0;
                end else begin
                    m_phase = m_phase + 5'd1;
                end
            end
            for (p = 0; p < 2; p++) begin
                if (run && ((p == 0) || launch1 || m_launched1)) begin
                    if (m_off[p] >= 10'd340) begin
                        m_off[p] = 10'd0;
                        m_gap[p] = gap_next;
                    end else begin
                        m_off[p] = m_off[p] + 10'd1;
                    end
                end
            end
            if (launch1) m_launched1 = 1'b1;
        end
        if (!ctrl) m_flap = 1'b1;
        else if (speed_old == 5'd0) m_flap = 1'b0;
        if (!ctrl) m_started = 1'b1;
        if (hit) m_over = 1'b1;
    endtask

    task automatic check_outputs();
        logic [35:0] e;
        assert (game_over === m_over) else begin
            $display("Mismatch game_over: got %h expected %h", game_over, m_over);
            err_over++;
        end
        assert (score === m_score) else begin
            $display("Mismatch score: got %h expected %h", score, m_score);
            err_score++;
        end
        if (exp_q.size() >= 2) begin
            e = exp_q.pop_front();
            assert (pix_data === e[15:0]) else begin
                $display("Mismatch pix_data at x %h y %h: got %h expected %h",
                         e[35:26], e[25:16], pix_data, e[15:0]);
                err_pix++;
            end
        end
    endtask

    task automatic drive_cycle(input coord_t x, input coord_t y, input logic ctrl);
        @(negedge vga_clk);
        sys_rst_n = 1'b1;
        check_outputs();
        exp_q.push_back({x, y, pixel_colour(int'(x), int'(y))});
        pix_x     = x;
        pix_y     = y;
        bird_ctrl = ctrl;
        model_step(x, y, ctrl);
    endtask

    task automatic apply_reset();
        @(negedge vga_clk);
        check_outputs();
        sys_rst_n = 1'b0;
        pix_x     = '0;
        pix_y     = '0;
        bird_ctrl = 1'b1;
        model_reset();
        repeat (2) @(negedge vga_clk);  // release comes with the next drive
    endtask

    task automatic random_pixel(output coord_t x, output coord_t y);
        int xi;
        int yi;
        rng = xorshift(rng);
        xi  = int'(rng[17:8]) % 640;
        yi  = int'(rng[27:18]) % 480;
        case (rng[1:0])
            2'd1: xi = 300 + int'(rng[7:2]) % 40;                      // bird columns
            2'd2: xi = 462 - int'(m_off[rng[31]]) + int'(rng[7:2]) % 56;  // near a pipe
            2'd3: yi = 415 + int'(rng[7:2]) % 65;                      // ground bands
            default: ;
        endcase
        x = coord_t'(xi);
        y = coord_t'(yi);
    endtask

    initial begin
        int     f;
        int     n;
        int     over_frames;
        logic   flap;
        coord_t x;
        coord_t y;
        vga_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        pix_x       = '0;
        pix_y       = '0;
        bird_ctrl   = 1'b1;
        rng         = 32'd14398;
        err_pix     = 0;
        err_score   = 0;
        err_over    = 0;
        over_frames = 0;
        model_reset();
        repeat (2) @(negedge vga_clk);
        for (f = 0; f < num_frames; f++) begin
            rng  = xorshift(rng);
            n    = int'(rng[7:0]) % 13;
            // about one frame in eight, more often while the bird is low
            flap = (m_bird_y < 10'd200) ? (rng[11:9] < 3'd2) : (rng[10:8] == 3'd0);
            repeat (n) begin
                random_pixel(x, y);
                drive_cycle(x, y, 1'b1);
            end
            if (flap) begin
                random_pixel(x, y);
                drive_cycle(x, y, 1'b0);
            end
            drive_cycle(10'd639, 10'd479, 1'b1);
            over_frames = m_over ? over_frames + 1 : 0;
            if (over_frames >= over_limit) begin
                apply_reset();
                over_frames = 0;
            end
        end
        repeat (2) drive_cycle(10'd0, 10'd0, 1'b1);     // drain the pixel pipeline
        $display("errors: pix_data %0d, score %0d, game_over %0d",
                 err_pix, err_score, err_over);
        if ((err_pix + err_score + err_over) == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/flappy_props.sv */
`timescale 1ns/1ns
`default_nettype none

module flappy_props (
    input wire                      vga_clk,
    input wire                      sys_rst_n,
    input wire flappy_pkg::rgb565_t pix_data,
    input wire                      game_over,
    input wire flappy_pkg::score_t  score
);

    // sticky until the next reset
    game_over_sticky: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n) game_over |=> game_over
    ) else $error("game_over fell while reset was inactive");

    score_step: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        (score == $past(score)) || (score == $past(score) + 20'd1)
    ) else $error("score changed by more than one in a single cycle");

    score_frozen: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n) game_over |=> $stable(score)
    ) else $error("score changed while game_over was set");

    pix_in_reset: assert property (
        @(posedge vga_clk) !sys_rst_n |-> (pix_data == '0)
    ) else $error("pix_data was not zero during reset");

endmodule

`default_nettype wire

/* source/flappy_pic.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module flappy_pic (
    input  wire                      vga_clk,
    input  wire                      sys_rst_n,
    input  wire flappy_pkg::coord_t  pix_x,
    input  wire flappy_pkg::coord_t  pix_y,
    input  wire                      bird_ctrl,
    output wire flappy_pkg::rgb565_t pix_data,
    output wire                      game_over,
    output wire flappy_pkg::score_t  score
);
    import flappy_pkg::*;

    wire          frame_end;
    wire          run;
    wire coord_t  new_gap;
    wire height_t bird_y;
    wire coord_t  pipe0_offset;
    wire coord_t  pipe1_offset;
    wire coord_t  pipe0_gap;
    wire coord_t  pipe1_gap;
    wire          pipe1_launch;
    wire layer_t  layer;
    wire          dim;

    // second pipe trails the first by half a lap
    assign pipe1_launch = (pipe0_offset == `FLAP_PIPE_MID);

    game_ctrl game_ctrl_i (
        .vga_clk      (vga_clk),
        .sys_rst_n    (sys_rst_n),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .bird_ctrl    (bird_ctrl),
        .bird_y       (bird_y),
        .pipe0_offset (pipe0_offset),
        .pipe1_offset (pipe1_offset),
        .pipe0_gap    (pipe0_gap),
        .pipe1_gap    (pipe1_gap),
        .frame_end    (frame_end),
        .run          (run),
        .game_over    (game_over),
        .new_gap      (new_gap),
        .score        (score)
    );

    bird_physics bird_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .frame_end (frame_end),
        .run       (run),
        .game_over (game_over),
        .bird_ctrl (bird_ctrl),
        .bird_y    (bird_y)
    );

    pipe_track #(.reset_gap(`FLAP_PIPE0_GAP)) pipe0_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .frame_end (frame_end),
        .run       (run),
        .launch    (1'b1),          // first pipe moves as soon as the game runs
        .new_gap   (new_gap),
        .offset    (pipe0_offset),
        .gap_top   (pipe0_gap)
    );

    pipe_track #(.reset_gap(coord_t'(`FLAP_LFSR_SEED))) pipe1_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .frame_end (frame_end),
        .run       (run),
        .launch    (pipe1_launch),
        .new_gap   (new_gap),
        .offset    (pipe1_offset),
        .gap_top   (pipe1_gap)
    );

    layer_hit layer_hit_i (
        .vga_clk      (vga_clk),
        .sys_rst_n    (sys_rst_n),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .bird_y       (bird_y),
        .pipe0_offset (pipe0_offset),
        .pipe1_offset (pipe1_offset),
        .pipe0_gap    (pipe0_gap),
        .pipe1_gap    (pipe1_gap),
        .game_over    (game_over),
        .layer        (layer),
        .dim          (dim)
    );

    pixel_compose pixel_compose_i (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .layer     (layer),
        .dim       (dim),
        .pix_data  (pix_data)
    );

endmodule

`default_nettype wire

/* source/pixel_compose.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module pixel_compose (
    input  wire                     vga_clk,
    input  wire                     sys_rst_n,
    input  wire flappy_pkg::layer_t layer,
    input  wire                     dim,
    output flappy_pkg::rgb565_t     pix_data
);
    import flappy_pkg::*;

    rgb565_t colour;
    rgb565_t colour_dim;

    always_comb begin
        case (layer)
            layer_pipe:  colour = `FLAP_COL_PIPE;
            layer_bird:  colour = `FLAP_COL_BIRD;
            layer_band1: colour = `FLAP_COL_BAND1;
            layer_band2: colour = `FLAP_COL_BAND2;
            layer_land:  colour = `FLAP_COL_LAND;
            layer_band3: colour = `FLAP_COL_BAND3;
            layer_band4: colour = `FLAP_COL_BAND4;
            layer_band5: colour = `FLAP_COL_BAND5;
            layer_sky:   colour = `FLAP_COL_SKY;
            default:     colour = `FLAP_COL_BLACK;    // outside play field
        endcase
    end

    // scale each channel separately, result truncates
    assign colour_dim[4:0]   = 5'(colour[4:0] * `FLAP_DIM_B / `FLAP_DIM_DIV);
    assign colour_dim[10:5]  = 6'(colour[10:5] * `FLAP_DIM_G / `FLAP_DIM_DIV);
    assign colour_dim[15:11] = 5'(colour[15:11] * `FLAP_DIM_R / `FLAP_DIM_DIV);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pix_data <= '0;
        end else begin
            pix_data <= dim ? colour_dim : colour;
        end
    end

endmodule

`default_nettype wire

/* source/layer_hit.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module layer_hit (
    input  wire                      vga_clk,
    input  wire                      sys_rst_n,
    input  wire flappy_pkg::coord_t  pix_x,
    input  wire flappy_pkg::coord_t  pix_y,
    input  wire flappy_pkg::height_t bird_y,
    input  wire flappy_pkg::coord_t  pipe0_offset,
    input  wire flappy_pkg::coord_t  pipe1_offset,
    input  wire flappy_pkg::coord_t  pipe0_gap,
    input  wire flappy_pkg::coord_t  pipe1_gap,
    input  wire                      game_over,
    output flappy_pkg::layer_t       layer,
    output logic                     dim
);
    import flappy_pkg::*;

    logic        in_black;
    logic        in_pipe;
    logic        in_bird;
    logic [10:0] bird_row;      // pixel row plus bird height
    layer_t      layer_next;

    // heads and bodies of one pipe, columns compared in offset 0 frame
    function automatic logic pipe_cover(
        input coord_t x,
        input coord_t y,
        input coord_t off,
        input coord_t gap
    );
        logic [10:0] xo;
        logic [10:0] low_head;  // first row of lower head
        logic        head_row;
        logic        body_row;
        xo       = 11'(x) + 11'(off);
        low_head = 11'(gap) + `FLAP_HEAD_H + `FLAP_PIPE_GAP;
        head_row = ((y >= gap) && (11'(y) < 11'(gap) + `FLAP_HEAD_H)) ||
                   ((11'(y) >= low_head) && (11'(y) < low_head + `FLAP_HEAD_H));
        body_row = (y < gap) || ((11'(y) >= low_head + `FLAP_HEAD_H) && (y < `FLAP_LAND_Y));
        return ((xo >= 11'(`FLAP_PIPE_X0)) && (xo < 11'(`FLAP_PIPE_X0 + `FLAP_HEAD_W)) &&
                head_row) ||
               ((xo >= 11'(`FLAP_PIPE_X0 + `FLAP_BODY_INSET)) &&
                (xo < 11'(`FLAP_PIPE_X0 + `FLAP_BODY_INSET + `FLAP_BODY_W)) && body_row);
    endfunction

    assign bird_row = 11'(pix_y) + 11'(bird_y);
    assign in_black = (pix_x < `FLAP_BG_X0) || (pix_x >= `FLAP_BG_X0 + `FLAP_BG_W);
    assign in_pipe  = pipe_cover(pix_x, pix_y, pipe0_offset, pipe0_gap) ||
                      pipe_cover(pix_x, pix_y, pipe1_offset, pipe1_gap);
    assign in_bird  = (pix_x >= `FLAP_BIRD_X0) && (pix_x < `FLAP_BIRD_X0 + `FLAP_BIRD_W) &&
                      (bird_row >= `FLAP_V_VALID - `FLAP_BIRD_H) && (bird_row < `FLAP_V_VALID);

    always_comb begin
        if (in_black) begin
            layer_next = layer_black;
        end else if (in_pipe) begin
            layer_next = layer_pipe;
        end else if (in_bird) begin
            layer_next = layer_bird;
        end else if (pix_y >= `FLAP_BAND5_Y) begin
            layer_next = layer_band5;
        end else if (pix_y >= `FLAP_BAND4_Y) begin
            layer_next = layer_band4;
        end else if (pix_y >= `FLAP_BAND3_Y) begin
            layer_next = layer_band3;
        end else if (pix_y >= `FLAP_LAND_BODY_Y) begin
            layer_next = layer_land;
        end else if (pix_y >= `FLAP_BAND2_Y) begin
            layer_next = layer_band2;
        end else if (pix_y >= `FLAP_LAND_Y) begin
            layer_next = layer_band1;
        end else begin
            layer_next = layer_sky;
        end
    end

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            layer <= layer_black;
            dim   <= 1'b0;
        end else begin
            layer <= layer_next;
            dim   <= game_over;     // keeps the grey-out aligned with the pixel
        end
    end

endmodule

`default_nettype wire

/* source/game_ctrl.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module game_ctrl (
    input  wire                     vga_clk,
    input  wire                     sys_rst_n,
    input  wire flappy_pkg::coord_t pix_x,
    input  wire flappy_pkg::coord_t pix_y,
    input  wire                     bird_ctrl,
    input  wire flappy_pkg::height_t bird_y,
    input  wire flappy_pkg::coord_t pipe0_offset,
    input  wire flappy_pkg::coord_t pipe1_offset,
    input  wire flappy_pkg::coord_t pipe0_gap,
    input  wire flappy_pkg::coord_t pipe1_gap,
    output logic                    frame_end,
    output logic                    run,
    output logic                    game_over,
    output flappy_pkg::coord_t      new_gap,
    output flappy_pkg::score_t      score
);

    localparam logic [10:0] bird_right = 11'(`FLAP_BIRD_X0 + `FLAP_BIRD_W);

    logic       started;
    logic [7:0] lfsr;
    logic       hit;

    // bird right edge inside the body columns and outside the gap rows
    function automatic logic pipe_hit(
        input logic [9:0] off,
        input logic [9:0] gap,
        input logic [9:0] by
    );
        logic [10:0] right_x;
        logic [11:0] y_gap;
        logic        in_body;
        right_x = bird_right + 11'(off);    // shifted into offset 0 frame
        y_gap   = 12'(by) + 12'(gap);
        in_body = (right_x >= 11'(`FLAP_PIPE_X0 + `FLAP_BODY_INSET)) &&
                  (right_x < 11'(`FLAP_PIPE_X0 + `FLAP_BODY_INSET + `FLAP_BODY_W));
        return in_body &&
               ((y_gap + `FLAP_HEAD_H >= `FLAP_V_VALID - `FLAP_BIRD_H) ||
                (y_gap + `FLAP_HEAD_H + `FLAP_PIPE_GAP + `FLAP_HEAD_H <= `FLAP_V_VALID));
    endfunction

    assign frame_end = (pix_x == `FLAP_H_VALID - 1'b1) && (pix_y == `FLAP_V_VALID - 1'b1);
    assign run       = started && !game_over;
    assign new_gap   = `FLAP_GAP_BASE + {3'b000, lfsr[6:0]};

    assign hit = (bird_y <= `FLAP_GROUND_HIT) ||
                 (bird_y >= `FLAP_V_VALID - `FLAP_BIRD_H) ||     // top row off screen
                 pipe_hit(pipe0_offset, pipe0_gap, bird_y) ||
                 pipe_hit(pipe1_offset, pipe1_gap, bird_y);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            started   <= 1'b0;
            game_over <= 1'b0;
        end else begin
            if (!bird_ctrl) begin
                started <= 1'b1;        // first press starts the game
            end
            if (hit) begin
                game_over <= 1'b1;      // sticky until reset
            end
        end
    end

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            lfsr  <= `FLAP_LFSR_SEED;
            score <= '0;
        end else if (frame_end) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (!game_over &&
                ((pipe0_offset == `FLAP_PIPE_MID) || (pipe1_offset == `FLAP_PIPE_MID))) begin
                score <= score + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/pipe_track.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module pipe_track #(
    parameter flappy_pkg::coord_t reset_gap = `FLAP_PIPE0_GAP
) (
    input  wire                 vga_clk,
    input  wire                 sys_rst_n,
    input  wire                 frame_end,
    input  wire                 run,
    input  wire                 launch,
    input  wire flappy_pkg::coord_t new_gap,
    output flappy_pkg::coord_t  offset,
    output flappy_pkg::coord_t  gap_top
);

    logic launched;     // launch seen at an earlier frame end
    logic moving;

    assign moving = run && (launch || launched);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            launched <= 1'b0;
        end else if (frame_end && launch) begin
            launched <= 1'b1;
        end
    end

    // scroll left one column per frame, wrap to the right edge with a fresh gap
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            offset  <= '0;
            gap_top <= reset_gap;
        end else if (frame_end && moving) begin
            if (offset >= `FLAP_PIPE_WRAP) begin
                offset  <= '0;
                gap_top <= new_gap;
            end else begin
                offset  <= offset + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/bird_physics.sv */
`timescale 1ns/1ns
`include "flappy_params.svh"
`default_nettype none

module bird_physics (
    input  wire                 vga_clk,
    input  wire                 sys_rst_n,
    input  wire                 frame_end,
    input  wire                 run,
    input  wire                 game_over,
    input  wire                 bird_ctrl,
    output flappy_pkg::height_t bird_y
);
    import flappy_pkg::*;

    logic       flap_active;    // climbing phase in progress
    logic [4:0] phase_cnt;      // frames into climb, or into fall step
    speed_t     speed;

    // button press starts a climb, ends once speed has run down to 0
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            flap_active <= 1'b0;
        end else if (!bird_ctrl) begin
            flap_active <= 1'b1;
        end else if (speed == '0) begin
            flap_active <= 1'b0;
        end
    end

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phase_cnt <= '0;
            speed     <= '0;
            bird_y    <= `FLAP_BIRD_START;
        end else if (frame_end) begin
            if (game_over) begin
                speed <= '0;                            // bird stays where it hit
            end else if (run && flap_active) begin
                bird_y <= bird_y + height_t'(speed);    // rise by old speed
                if (phase_cnt < 5'd5) begin
                    speed <= 5'd6;
                end else if (phase_cnt < 5'd10) begin
                    speed <= 5'd4;
                end else if (phase_cnt < 5'd15) begin
                    speed <= 5'd2;
                end else if (phase_cnt < 5'd20) begin
                    speed <= 5'd1;
                end else begin
                    speed <= '0;                        // climb finished
                end
                if (phase_cnt >= 5'd20) begin
                    phase_cnt <= '0;
                end else begin
                    phase_cnt <= phase_cnt + 1'b1;
                end
            end else if (run) begin
                bird_y <= bird_y - height_t'(speed);    // gravity
                if (phase_cnt >= 5'd3) begin
                    speed     <= speed + 1'b1;          // speeds up every 4th frame
                    phase_cnt <= '0;
                end else begin
                    phase_cnt <= phase_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/flappy_pkg.sv */
`default_nettype none

package flappy_pkg;

    typedef logic [9:0]  coord_t;       // pixel coordinate or pipe offset
    typedef logic [15:0] rgb565_t;
    typedef logic [9:0]  height_t;      // bird height above screen bottom
    typedef logic [4:0]  speed_t;
    typedef logic [19:0] score_t;

    // listed from highest to lowest drawing priority
    typedef enum logic [3:0] {
        layer_black,
        layer_pipe,
        layer_bird,
        layer_band1,
        layer_band2,
        layer_land,
        layer_band3,
        layer_band4,
        layer_band5,
        layer_sky
    } layer_t;

endpackage

`default_nettype wire

/* source/flappy_params.svh */
`default_nettype none

`ifndef FLAPPY_PARAMS_SVH
`define FLAPPY_PARAMS_SVH

// active area, the frame ends on its last pixel
`define FLAP_H_VALID        10'd640
`define FLAP_V_VALID        10'd480

`define FLAP_BG_X0          10'd176     // left edge of play field
`define FLAP_BG_W           10'd288

// ground, first row of each band
`define FLAP_LAND_Y         10'd420
`define FLAP_BAND2_Y        10'd422
`define FLAP_LAND_BODY_Y    10'd424
`define FLAP_BAND3_Y        10'd438
`define FLAP_BAND4_Y        10'd440
`define FLAP_BAND5_Y        10'd442     // down to the bottom of the screen

`define FLAP_BIRD_W         10'd34
`define FLAP_BIRD_H         10'd27
`define FLAP_BIRD_X0        10'd303
`define FLAP_BIRD_START     10'd226     // height above screen bottom
`define FLAP_GROUND_HIT     10'd60

`define FLAP_PIPE_X0        10'd464     // left edge at offset 0
`define FLAP_HEAD_W         10'd52
`define FLAP_HEAD_H         10'd24
`define FLAP_BODY_INSET     10'd2
`define FLAP_BODY_W         10'd48
`define FLAP_PIPE_GAP       10'd110
`define FLAP_PIPE_WRAP      10'd340     // field width plus head width
`define FLAP_PIPE_MID       10'd170
`define FLAP_PIPE0_GAP      10'd150
`define FLAP_GAP_BASE       10'd40
`define FLAP_LFSR_SEED      8'hA5

`define FLAP_COL_SKY        16'h4E19
`define FLAP_COL_BAND1      16'h51C8
`define FLAP_COL_BAND2      16'hE7F1
`define FLAP_COL_LAND       16'hDED2
`define FLAP_COL_BAND3      16'h5404
`define FLAP_COL_BAND4      16'hD549
`define FLAP_COL_BAND5      16'hDED2
`define FLAP_COL_PIPE       16'h07E0
`define FLAP_COL_BIRD       16'hFFE0
`define FLAP_COL_BLACK      16'h0000

// grey-out after game over, per channel
`define FLAP_DIM_B          30
`define FLAP_DIM_G          39
`define FLAP_DIM_R          11
`define FLAP_DIM_DIV        100

`endif

`default_nettype wire
